// ==== design/dpc_geom_pkg.sv ====
// frame geometry for the bad-pixel detector
// frame size in pixels and the pixel coordinate word
package dpc_geom_pkg;

  // ============================================================
  // frame size
  // ============================================================
  localparam int FRAME_W = 16;   // pixels per line
  localparam int FRAME_H = 8;    // lines per frame

  // ============================================================
  // coordinates
  // ============================================================
  // wide enough for full-size sensors
  localparam int COORD_W = 10;

  typedef logic [COORD_W-1:0] coord_t;

endpackage

// ==== design/dpc_data_pkg.sv ====
// data definitions for the bad-pixel detector
// k value word, bad-pixel list entry and count, judge pipeline depth
package dpc_data_pkg;

  // ============================================================
  // k values
  // ============================================================
  localparam int K_W = 16;

  typedef logic [K_W-1:0] k_t;   // per-pixel gain, zero means dead

  // ============================================================
  // bad-pixel list
  // ============================================================
  localparam int BP_LIST_DEPTH = 16;
  localparam int LIST_AW       = $clog2(BP_LIST_DEPTH);

  typedef logic [LIST_AW:0] count_t;   // extra bit so a full list reads as 16

  // each half of the entry is a 16-bit slot with the coordinate right-aligned
  localparam int PAD_W = 16 - dpc_geom_pkg::COORD_W;

  typedef union packed {
    logic [31:0] raw;   // as seen on read_data
    struct packed {
      logic [PAD_W-1:0]     pad_y;
      dpc_geom_pkg::coord_t y;
      logic [PAD_W-1:0]     pad_x;
      dpc_geom_pkg::coord_t x;
    } coord;
  } bp_entry_u;

  // ============================================================
  // judge pipeline
  // ============================================================
  localparam int MEDIAN_STAGES = 3;   // register stages in the sorter

endpackage

// ==== design/k_window_builder.sv ====
// k window builder
// turns the raster k stream into one edge-replicated 3x3 window per pixel,
// using two line buffers and a three-column shift register. after the
// last input of a frame it drains itself with internal strokes.
`timescale 1ns/1ps

module k_window_builder (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 k_valid,
  input  dpc_data_pkg::k_t     k_data,
  output logic                 win_valid,
  output dpc_geom_pkg::coord_t win_x,
  output dpc_geom_pkg::coord_t win_y,
  output dpc_data_pkg::k_t     k11,
  output dpc_data_pkg::k_t     k12,
  output dpc_data_pkg::k_t     k13,
  output dpc_data_pkg::k_t     k21,
  output dpc_data_pkg::k_t     k22,
  output dpc_data_pkg::k_t     k23,
  output dpc_data_pkg::k_t     k31,
  output dpc_data_pkg::k_t     k32,
  output dpc_data_pkg::k_t     k33
);
  import dpc_geom_pkg::*;
  import dpc_data_pkg::*;

  localparam int XW        = $clog2(FRAME_W);
  localparam int DRAIN_LEN = FRAME_W + 1;   // centres left after the last input

  coord_t sx;          // stroke column
  coord_t sy;          // stroke row that runs past the frame while draining
  coord_t drain_cnt;
  coord_t cx;
  coord_t cy;
  logic   draining;
  logic   stroke;
  logic   last_in;
  logic   issue;

  k_t     lb1 [FRAME_W];   // one line back
  k_t     lb2 [FRAME_W];   // two lines back
  k_t     lb1_rd;
  k_t     lb2_rd;

  k_t     cols [3][3];     // [column][row], column 0 newest
  k_t     hw   [3][3];     // [row][column] after left/right clamp
  k_t     win  [3][3];     // [row][column] after top/bottom clamp

  logic   s1_valid;
  coord_t s1_x;
  coord_t s1_y;

  // ============================================================
  // stroke counters and drain
  // ============================================================
  assign draining = (drain_cnt != '0);
  assign stroke   = k_valid || draining;
  assign last_in  = k_valid && (sx == coord_t'(FRAME_W - 1)) && (sy == coord_t'(FRAME_H - 1));

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      sx        <= '0;
      sy        <= '0;
      drain_cnt <= '0;
    end
    else
    begin
      if (stroke)
      begin
        if (draining && drain_cnt == coord_t'(1))   // rewind after the last centre
        begin
          sx <= '0;
          sy <= '0;
        end
        else if (sx == coord_t'(FRAME_W - 1))
        begin
          sx <= '0;
          sy <= sy + coord_t'(1);
        end
        else
        begin
          sx <= sx + coord_t'(1);
        end
      end
      if (last_in)
        drain_cnt <= coord_t'(DRAIN_LEN);
      else if (draining)
        drain_cnt <= drain_cnt - coord_t'(1);
    end
  end

  // centre lags the stroke by one line and one pixel
  always_comb
  begin
    issue = (sy > coord_t'(1)) || ((sy == coord_t'(1)) && (sx != '0));
    if (sx == '0)
    begin
      cx = coord_t'(FRAME_W - 1);   // wrapped back to the end of the line above
      cy = sy - coord_t'(2);
    end
    else
    begin
      cx = sx - coord_t'(1);
      cy = sy - coord_t'(1);
    end
  end

  // ============================================================
  // line buffers and column shift
  // ============================================================
  assign lb1_rd = lb1[sx[XW-1:0]];
  assign lb2_rd = lb2[sx[XW-1:0]];

  always_ff @(posedge aclk)
  begin
    if (stroke)
    begin
      lb1[sx[XW-1:0]] <= k_data;
      lb2[sx[XW-1:0]] <= lb1_rd;
      cols[0][0]      <= lb2_rd;
      cols[0][1]      <= lb1_rd;
      cols[0][2]      <= k_data;
      cols[1]         <= cols[0];
      cols[2]         <= cols[1];
    end
  end

  // replicate across frame edges with columns first so corners take the centre
  always_comb
  begin
    for (int r = 0; r < 3; r++)
    begin
      hw[r][0] = (s1_x == '0) ? cols[1][r] : cols[2][r];
      hw[r][1] = cols[1][r];
      hw[r][2] = (s1_x == coord_t'(FRAME_W - 1)) ? cols[1][r] : cols[0][r];
    end
    for (int c = 0; c < 3; c++)
    begin
      win[0][c] = (s1_y == '0) ? hw[1][c] : hw[0][c];
      win[1][c] = hw[1][c];
      win[2][c] = (s1_y == coord_t'(FRAME_H - 1)) ? hw[1][c] : hw[2][c];
    end
  end

  // ============================================================
  // two-stage output pipe
  // ============================================================
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      s1_valid  <= 1'b0;
      win_valid <= 1'b0;
    end
    else
    begin
      s1_valid  <= stroke && issue;
      win_valid <= s1_valid;
    end
  end

  always_ff @(posedge aclk)
  begin
    s1_x  <= cx;
    s1_y  <= cy;
    win_x <= s1_x;
    win_y <= s1_y;
    k11   <= win[0][0];
    k12   <= win[0][1];
    k13   <= win[0][2];
    k21   <= win[1][0];
    k22   <= win[1][1];
    k23   <= win[1][2];
    k31   <= win[2][0];
    k32   <= win[2][1];
    k33   <= win[2][2];
  end

endmodule

// ==== design/deviation_judge.sv ====
// deviation judge
// drops dead neighbours, takes the lower median of the rest through a
// pipelined sorting network and flags the centre when it is dead or too
// far from that median. fixed 5-cycle latency, fully pipelined.
`timescale 1ns/1ps

module deviation_judge (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 win_valid,
  input  dpc_geom_pkg::coord_t win_x,
  input  dpc_geom_pkg::coord_t win_y,
  input  dpc_data_pkg::k_t     k11,
  input  dpc_data_pkg::k_t     k12,
  input  dpc_data_pkg::k_t     k13,
  input  dpc_data_pkg::k_t     k21,
  input  dpc_data_pkg::k_t     k22,
  input  dpc_data_pkg::k_t     k23,
  input  dpc_data_pkg::k_t     k31,
  input  dpc_data_pkg::k_t     k32,
  input  dpc_data_pkg::k_t     k33,
  input  dpc_data_pkg::k_t     k_threshold,
  output logic                 bp_valid,
  output dpc_geom_pkg::coord_t bp_x,
  output dpc_geom_pkg::coord_t bp_y,
  output dpc_data_pkg::k_t     bp_k,
  output logic                 centre_done
);
  import dpc_geom_pkg::*;
  import dpc_data_pkg::*;

  localparam int NB    = 8;
  localparam int NPAIR = 19;
  localparam int LAST  = MEDIAN_STAGES;

  // batcher odd-even merge sort for 8 with two comparator layers per stage
  localparam int CMP_A [NPAIR] = '{0, 2, 4, 6, 0, 1, 4, 5, 1, 5, 0, 1, 2, 3, 2, 3, 1, 3, 5};
  localparam int CMP_B [NPAIR] = '{1, 3, 5, 7, 2, 3, 6, 7, 2, 6, 4, 5, 6, 7, 4, 5, 2, 4, 6};
  localparam int STAGE_LO [MEDIAN_STAGES+1] = '{0, 8, 14, 19};

  typedef k_t [NB-1:0] kvec_t;

  k_t         nb [NB];
  kvec_t      packed_nb;
  logic [3:0] packed_n;      // valid neighbours, 0..8

  kvec_t      srt_q    [MEDIAN_STAGES+1];
  kvec_t      srt_d    [MEDIAN_STAGES];
  logic       sb_valid [MEDIAN_STAGES+1];
  coord_t     sb_x     [MEDIAN_STAGES+1];
  coord_t     sb_y     [MEDIAN_STAGES+1];
  k_t         sb_k     [MEDIAN_STAGES+1];
  logic [3:0] sb_n     [MEDIAN_STAGES+1];

  k_t         median;
  k_t         delta;
  logic       is_bad;

  // ============================================================
  // gather
  // ============================================================
  always_comb
  begin
    nb[0] = k11;
    nb[1] = k12;
    nb[2] = k13;
    nb[3] = k21;
    nb[4] = k23;
    nb[5] = k31;
    nb[6] = k32;
    nb[7] = k33;
  end

  always_comb
  begin
    packed_nb = '1;   // empty slots sort to the top
    packed_n  = '0;
    for (int i = 0; i < NB; i++)
    begin
      if (nb[i] != '0)
      begin
        packed_nb[packed_n] = nb[i];
        packed_n            = packed_n + 4'd1;
      end
    end
  end

  // ============================================================
  // sorting network
  // ============================================================
  always_comb
  begin
    k_t lo;
    k_t hi;
    for (int st = 0; st < MEDIAN_STAGES; st++)
    begin
      srt_d[st] = srt_q[st];
      for (int p = STAGE_LO[st]; p < STAGE_LO[st+1]; p++)
      begin
        lo = (srt_d[st][CMP_A[p]] > srt_d[st][CMP_B[p]]) ? srt_d[st][CMP_B[p]]
                                                         : srt_d[st][CMP_A[p]];
        hi = (srt_d[st][CMP_A[p]] > srt_d[st][CMP_B[p]]) ? srt_d[st][CMP_A[p]]
                                                         : srt_d[st][CMP_B[p]];
        srt_d[st][CMP_A[p]] = lo;
        srt_d[st][CMP_B[p]] = hi;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      for (int st = 0; st <= MEDIAN_STAGES; st++)
        sb_valid[st] <= 1'b0;
    end
    else
    begin
      sb_valid[0] <= win_valid;
      for (int st = 0; st < MEDIAN_STAGES; st++)
        sb_valid[st+1] <= sb_valid[st];
    end
  end

  always_ff @(posedge aclk)
  begin
    srt_q[0] <= packed_nb;
    sb_x[0]  <= win_x;
    sb_y[0]  <= win_y;
    sb_k[0]  <= k22;        // centre rides alongside
    sb_n[0]  <= packed_n;
    for (int st = 0; st < MEDIAN_STAGES; st++)
    begin
      srt_q[st+1] <= srt_d[st];
      sb_x[st+1]  <= sb_x[st];
      sb_y[st+1]  <= sb_y[st];
      sb_k[st+1]  <= sb_k[st];
      sb_n[st+1]  <= sb_n[st];
    end
  end

  // ============================================================
  // compare
  // ============================================================
  always_comb
  begin
    median = (sb_n[LAST] == '0) ? '0 : srt_q[LAST][(sb_n[LAST] - 4'd1) >> 1];   // lower median
    delta  = (sb_k[LAST] > median) ? sb_k[LAST] - median : median - sb_k[LAST];
    is_bad = (sb_k[LAST] == '0) || (delta > k_threshold);
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      bp_valid    <= 1'b0;
      centre_done <= 1'b0;
    end
    else
    begin
      bp_valid    <= sb_valid[LAST] && is_bad;
      centre_done <= sb_valid[LAST] && (sb_x[LAST] == coord_t'(FRAME_W - 1))
                     && (sb_y[LAST] == coord_t'(FRAME_H - 1));
    end
  end

  always_ff @(posedge aclk)
  begin
    bp_x <= sb_x[LAST];
    bp_y <= sb_y[LAST];
    bp_k <= sb_k[LAST];
  end

endmodule

// ==== design/bp_list_recorder.sv ====
// bad-pixel list recorder
// stores reported coordinates in a small list, keeps a saturating
// per-frame count, serves readback and flags the end of each frame
`timescale 1ns/1ps

module bp_list_recorder (
  input  logic                             aclk,
  input  logic                             aresetn,
  input  logic                             bp_valid,
  input  dpc_geom_pkg::coord_t             bp_x,
  input  dpc_geom_pkg::coord_t             bp_y,
  input  logic                             centre_done,
  input  logic                             frame_start,
  input  logic [dpc_data_pkg::LIST_AW-1:0] read_addr,
  output dpc_data_pkg::count_t             bp_count,
  output logic                             frame_done,
  output logic [31:0]                      read_data
);
  import dpc_data_pkg::*;

  bp_entry_u list_mem [BP_LIST_DEPTH];
  bp_entry_u wr_entry;
  bp_entry_u rd_entry;
  logic      wr_en;

  // ============================================================
  // write side
  // ============================================================
  assign wr_en = bp_valid && (bp_count < count_t'(BP_LIST_DEPTH));   // drop once full

  always_comb
  begin
    wr_entry.raw     = '0;
    wr_entry.coord.y = bp_y;
    wr_entry.coord.x = bp_x;
  end

  always_ff @(posedge aclk)
  begin
    if (wr_en)
      list_mem[bp_count[LIST_AW-1:0]] <= wr_entry;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      bp_count   <= '0;
      frame_done <= 1'b0;
    end
    else
    begin
      if (frame_start)
        bp_count <= '0;   // new frame
      else if (wr_en)
        bp_count <= bp_count + count_t'(1);
      frame_done <= centre_done;
    end
  end

  // ============================================================
  // readback
  // ============================================================
  assign rd_entry  = list_mem[read_addr];
  assign read_data = ({1'b0, read_addr} < bp_count) ? rd_entry.raw : '0;   // unwritten slots read 0

endmodule

// ==== design/dpc_detector.sv ====
// streaming bad-pixel detector top level
// window builder -> deviation judge -> list recorder, plus the idle flag
// that marks the first k value of each frame
`timescale 1ns/1ps

module dpc_detector (
  input  logic                             aclk,
  input  logic                             aresetn,
  input  logic                             k_valid,
  input  dpc_data_pkg::k_t                 k_data,
  input  dpc_data_pkg::k_t                 k_threshold,
  input  logic [dpc_data_pkg::LIST_AW-1:0] read_addr,
  output logic                             bp_valid,
  output dpc_geom_pkg::coord_t             bp_x,
  output dpc_geom_pkg::coord_t             bp_y,
  output dpc_data_pkg::k_t                 bp_k,
  output dpc_data_pkg::count_t             bp_count,
  output logic                             frame_done,
  output logic [31:0]                      read_data
);
  import dpc_geom_pkg::*;
  import dpc_data_pkg::*;

  logic   win_valid;
  coord_t win_x;
  coord_t win_y;
  k_t     win_k11;
  k_t     win_k12;
  k_t     win_k13;
  k_t     win_k21;
  k_t     win_k22;
  k_t     win_k23;
  k_t     win_k31;
  k_t     win_k32;
  k_t     win_k33;
  logic   centre_done;
  logic   idle;          // between frames
  logic   frame_start;

  // ============================================================
  // frame start detection
  // ============================================================
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      idle <= 1'b1;
    else if (k_valid)
      idle <= 1'b0;
    else if (frame_done)
      idle <= 1'b1;
  end

  assign frame_start = k_valid && idle;

  // ============================================================
  // stages
  // ============================================================
  k_window_builder u_builder (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .k_valid   (k_valid),
    .k_data    (k_data),
    .win_valid (win_valid),
    .win_x     (win_x),
    .win_y     (win_y),
    .k11       (win_k11),
    .k12       (win_k12),
    .k13       (win_k13),
    .k21       (win_k21),
    .k22       (win_k22),
    .k23       (win_k23),
    .k31       (win_k31),
    .k32       (win_k32),
    .k33       (win_k33)
  );

  deviation_judge u_judge (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .win_valid   (win_valid),
    .win_x       (win_x),
    .win_y       (win_y),
    .k11         (win_k11),
    .k12         (win_k12),
    .k13         (win_k13),
    .k21         (win_k21),
    .k22         (win_k22),
    .k23         (win_k23),
    .k31         (win_k31),
    .k32         (win_k32),
    .k33         (win_k33),
    .k_threshold (k_threshold),
    .bp_valid    (bp_valid),
    .bp_x        (bp_x),
    .bp_y        (bp_y),
    .bp_k        (bp_k),
    .centre_done (centre_done)
  );

  bp_list_recorder u_recorder (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .bp_valid    (bp_valid),
    .bp_x        (bp_x),
    .bp_y        (bp_y),
    .centre_done (centre_done),
    .frame_start (frame_start),
    .read_addr   (read_addr),
    .bp_count    (bp_count),
    .frame_done  (frame_done),
    .read_data   (read_data)
  );

endmodule

// ==== tests/dpc_detector_assert.sv ====
// port checks for the bad-pixel detector
// frame_done pulse width, count range and when the count may move
`timescale 1ns/1ps

module dpc_detector_assert (
  input logic                 aclk,
  input logic                 aresetn,
  input logic                 k_valid,
  input logic                 bp_valid,
  input dpc_data_pkg::count_t bp_count,
  input logic                 frame_done
);
  import dpc_data_pkg::*;

  int pulse_errs  = 0;   // failures per property
  int range_errs  = 0;
  int change_errs = 0;

  frame_done_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
    frame_done |=> !frame_done)
  else
  begin
    pulse_errs++;
    $error("frame_done stayed high for more than one cycle");
  end

  count_in_range: assert property (@(posedge aclk) disable iff (!aresetn)
    bp_count <= count_t'(BP_LIST_DEPTH))
  else
  begin
    range_errs++;
    $error("bp_count went above the list depth");
  end

  // the count steps up by one after a report and clears only on a k strobe
  count_moves_on_event: assert property (@(posedge aclk) disable iff (!aresetn)
    !$stable(bp_count) |->
      (($past(bp_valid) && (bp_count == count_t'($past(bp_count) + count_t'(1))))
       || ((bp_count == '0) && $past(k_valid))))
  else
  begin
    change_errs++;
    $error("bp_count changed without a report or a frame start");
  end

endmodule

bind dpc_detector dpc_detector_assert u_assert (
  .aclk       (aclk),
  .aresetn    (aresetn),
  .k_valid    (k_valid),
  .bp_valid   (bp_valid),
  .bp_count   (bp_count),
  .frame_done (frame_done)
);

// ==== tests/tb_dpc_detector.sv ====
// testbench for the streaming bad-pixel detector
// replays the golden k maps one frame at a time, then checks the reports,
// the final count and the readback of every list address
`timescale 1ns/1ps

module tb_dpc_detector;
  import dpc_geom_pkg::*;
  import dpc_data_pkg::*;

  localparam string GOLDEN      = "tests/dpc_golden.txt";
  localparam int    TEST_CYCLES = FRAME_W * FRAME_H + FRAME_W + 40;

  logic               aclk;
  logic               aresetn;
  logic               k_valid;
  k_t                 k_data;
  k_t                 k_threshold;
  logic [LIST_AW-1:0] read_addr;
  logic               bp_valid;
  coord_t             bp_x;
  coord_t             bp_y;
  k_t                 bp_k;
  count_t             bp_count;
  logic               frame_done;
  logic [31:0]        read_data;

  // current test from the golden file
  string  test_name;
  k_t     test_thr;
  count_t exp_count;
  k_t     kmap [FRAME_H][FRAME_W];
  coord_t exp_x [$];
  coord_t exp_y [$];
  k_t     exp_k [$];
  coord_t got_x [$];   // filled by the report monitor
  coord_t got_y [$];
  k_t     got_k [$];

  int fd;
  int n_tests;
  int err_cnt;
  int tests_ok;
  int tests_bad;
  int assert_fails;

  dpc_detector DUT (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .k_valid     (k_valid),
    .k_data      (k_data),
    .k_threshold (k_threshold),
    .read_addr   (read_addr),
    .bp_valid    (bp_valid),
    .bp_x        (bp_x),
    .bp_y        (bp_y),
    .bp_k        (bp_k),
    .bp_count    (bp_count),
    .frame_done  (frame_done),
    .read_data   (read_data)
  );

  initial aclk = 1'b0;
  always #5 aclk = ~aclk;

  // ============================================================
  // compare tasks
  // ============================================================
  task automatic check_coord(input string name, input coord_t got, input coord_t exp);
    if (got !== exp)
    begin
      $display("ERR %0s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_k(input string name, input k_t got, input k_t exp);
    if (got !== exp)
    begin
      $display("ERR %0s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp)
    begin
      $display("ERR %0s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_entry(input string name, input bp_entry_u got, input bp_entry_u exp);
    if (got.raw !== exp.raw)
    begin
      $display("ERR %0s got %h (x %h y %h) expected %h (x %h y %h)", name,
               got.raw, got.coord.x, got.coord.y, exp.raw, exp.coord.x, exp.coord.y);
      err_cnt++;
    end
  endtask

  // ============================================================
  // golden file
  // ============================================================
  // next data line with blank and # lines skipped
  function automatic bit read_line(output string line);
    int rc;
    line = "";
    while (!$feof(fd))
    begin
      rc = $fgets(line, fd);
      if (rc > 1 && line.getc(0) != "#")
        return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic load_test(output bit ok);
    string line;
    int    n_rep;
    int    cnt;
    int    x;
    int    y;
    int    k;
    ok = 1'b0;
    exp_x.delete();
    exp_y.delete();
    exp_k.delete();
    if (!read_line(line) ||
        $sscanf(line, "test %s %h %d %d", test_name, test_thr, n_rep, cnt) != 4)
    begin
      $display("golden file has a missing or malformed test header");
      return;
    end
    for (int r = 0; r < FRAME_H; r++)
    begin
      if (!read_line(line) || line.len() < 5 * FRAME_W - 1)
      begin
        $display("golden file row %0d of test %0s is short or missing", r, test_name);
        return;
      end
      for (int c = 0; c < FRAME_W; c++)
        kmap[r][c] = k_t'(line.substr(5 * c, 5 * c + 3).atohex());   // fixed 4-digit columns
    end
    for (int i = 0; i < n_rep; i++)
    begin
      if (!read_line(line) || $sscanf(line, "%d %d %h", x, y, k) != 3)
      begin
        $display("golden file report %0d of test %0s is malformed", i, test_name);
        return;
      end
      exp_x.push_back(coord_t'(x));
      exp_y.push_back(coord_t'(y));
      exp_k.push_back(k_t'(k));
    end
    exp_count = count_t'(cnt);
    ok        = 1'b1;
  endtask

  // ============================================================
  // stimulus and monitor
  // ============================================================
  task automatic drive_k(input logic valid, input k_t data);
    @(posedge aclk);
    #1;
    k_valid = valid;
    k_data  = data;
  endtask

  always @(negedge aclk)
  begin
    if (aresetn === 1'b1 && bp_valid === 1'b1)
    begin
      got_x.push_back(bp_x);
      got_y.push_back(bp_y);
      got_k.push_back(bp_k);
    end
  end

  task automatic reset_dut();
    repeat (4) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    @(negedge aclk);
    check_count("bp_count", bp_count, '0);
  endtask

  task automatic run_test();
    bp_entry_u exp_e;
    bp_entry_u got_e;
    int        errs_before;
    int        n;
    errs_before = err_cnt;
    got_x.delete();
    got_y.delete();
    got_k.delete();
    @(posedge aclk);
    #1;
    k_threshold = test_thr;   // stable for the whole frame
    for (int y = 0; y < FRAME_H; y++)
      for (int x = 0; x < FRAME_W; x++)
        drive_k(1'b1, kmap[y][x]);
    drive_k(1'b0, '0);
    do
      @(negedge aclk);
    while (frame_done !== 1'b1);

    if (got_x.size() != exp_x.size())
    begin
      $display("test %0s saw %0d reports where %0d were expected",
               test_name, got_x.size(), exp_x.size());
      err_cnt++;
    end
    n = (got_x.size() < exp_x.size()) ? got_x.size() : exp_x.size();
    for (int i = 0; i < n; i++)
    begin
      check_coord("bp_x", got_x[i], exp_x[i]);
      check_coord("bp_y", got_y[i], exp_y[i]);
      check_k("bp_k", got_k[i], exp_k[i]);
    end
    check_count("bp_count", bp_count, exp_count);

    // addresses past the count read zero
    for (int a = 0; a < BP_LIST_DEPTH; a++)
    begin
      @(posedge aclk);
      #1;
      read_addr = a[LIST_AW-1:0];
      #4;
      got_e.raw = read_data;
      exp_e.raw = '0;
      if (a < int'(exp_count) && a < exp_x.size())
      begin
        exp_e.coord.x = exp_x[a];
        exp_e.coord.y = exp_y[a];
      end
      check_entry("read_data", got_e, exp_e);
    end

    if (err_cnt == errs_before)
    begin
      tests_ok++;
      $display("test %0s ok, %0d reports", test_name, got_x.size());
    end
    else
    begin
      tests_bad++;
      $display("test %0s failed with %0d errors", test_name, err_cnt - errs_before);
    end
  endtask

  // ============================================================
  // main sequence and watchdog
  // ============================================================
  initial
  begin
    bit    ok;
    string line;
    aresetn     = 1'b0;
    k_valid     = 1'b0;
    k_data      = '0;
    k_threshold = '0;
    read_addr   = '0;
    err_cnt     = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    fd = $fopen(GOLDEN, "r");
    if (fd == 0)
    begin
      $display("cannot open the golden file %0s", GOLDEN);
      err_cnt++;
    end
    else if (!read_line(line) || $sscanf(line, "tests %d", n_tests) != 1 || n_tests < 1)
    begin
      $display("golden file does not start with a test count");
      err_cnt++;
    end
    else
    begin
      reset_dut();
      for (int t = 0; t < n_tests; t++)
      begin
        load_test(ok);
        if (!ok)
        begin
          err_cnt++;
          tests_bad++;
          break;
        end
        run_test();
      end
      $fclose(fd);
    end
    assert_fails = DUT.u_assert.pulse_errs + DUT.u_assert.range_errs
                   + DUT.u_assert.change_errs;
    $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             tests_ok, tests_bad, assert_fails);
    if (err_cnt == 0 && tests_bad == 0 && assert_fails == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    wait (n_tests > 0);
    repeat (n_tests * TEST_CYCLES + 100) @(posedge aclk);
    $display("timeout: the run did not finish within %0d cycles",
             n_tests * TEST_CYCLES + 100);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== tests/dpc_golden.txt ====
# first data line: tests <count>. per test: test <name> <threshold hex> <reports> <final count>,
# then 8 rows of 16 four-digit hex k values, then one line per report: x y k(hex)
tests 5
test uniform 0010 0 0
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
test dead_pixels 0010 4 4
0000 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200
0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200
0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200
0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0000
0200 0200 0200 0200 0200 0200 0000 0200 0200 0200 0200 0200 0200 0200 0200 0200
0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200
0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200 0200
0200 0200 0200 0200 0200 0200 0200 0200 0200 0000 0200 0200 0200 0200 0200 0200
0 0 0000
15 3 0000
6 4 0000
9 7 0000
test deviation 0020 2 2
0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300
0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300
0300 0300 0300 0300 0321 0300 0300 0300 0300 0300 0320 0300 0300 0300 0300 0300
0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300
0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300
0300 0300 0300 0300 02DF 0300 0300 0300 0300 0300 02E0 0300 0300 0300 0300 0300
0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300
0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300 0300
4 2 0321
4 5 02DF
test list_overflow 0010 17 16
0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400
0000 0400 0000 0400 0000 0400 0000 0400 0000 0400 0000 0400 0000 0400 0000 0400
0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400
0400 0000 0400 0000 0400 0000 0400 0000 0400 0000 0400 0000 0400 0000 0400 0000
0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400
0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400
0000 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400
0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400
0 1 0000
2 1 0000
4 1 0000
6 1 0000
8 1 0000
10 1 0000
12 1 0000
14 1 0000
1 3 0000
3 3 0000
5 3 0000
7 3 0000
9 3 0000
11 3 0000
13 3 0000
15 3 0000
0 6 0000
test second_frame 0010 2 2
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0000 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0000 0100 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
5 2 0000
12 6 0000

// ==== dpc_detector.f ====
design/dpc_geom_pkg.sv
design/dpc_data_pkg.sv
design/k_window_builder.sv
design/deviation_judge.sv
design/bp_list_recorder.sv
design/dpc_detector.sv
tests/dpc_detector_assert.sv
tests/tb_dpc_detector.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the dpc_detector testbench with Verilator, run it, look for the pass message
verilator --binary --timing --assert -Wno-fatal --top-module tb_dpc_detector \
  -f dpc_detector.f -o tb_dpc_detector \
  && ./obj_dir/tb_dpc_detector +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -q "Simulation PASSED" \
  && echo "run_sim: pass" \
  || { echo "run_sim: fail"; exit 1; }
